/* design/input_buffer.sv */
`timescale 1ns/1ps
`default_nettype none

module input_buffer #(
	parameter int BUFFER_DEPTH = 4
) (
	input  wire logic           clk,
	input  wire logic           reset_i,
	input  noc_pkg::link_t      link_i,
	input  wire logic           pop_i,
	output noc_pkg::flit_t      head_o,
	output logic                not_empty_o,
	output logic                credit_o
);

	localparam int PTR_W = (BUFFER_DEPTH > 1) ? $clog2(BUFFER_DEPTH) : 1;
	localparam int CNT_W = $clog2(BUFFER_DEPTH + 1);

	typedef logic [PTR_W-1:0] ptr_t;
	typedef logic [CNT_W-1:0] cnt_t;

	noc_pkg::flit_t mem [BUFFER_DEPTH];
	ptr_t           wr_ptr;
	ptr_t           rd_ptr;
	cnt_t           count;

	function automatic ptr_t ptr_next(input ptr_t ptr);
		ptr_t nxt;
		if (ptr == ptr_t'(BUFFER_DEPTH - 1)) begin
			nxt = '0;
		end else begin
			nxt = ptr + 1'b1;
		end
		return nxt;
	endfunction

	always_ff @(posedge clk) begin
		if (link_i.valid) begin
			mem[wr_ptr] <= link_i.flit;
		end
	end

	always_ff @(posedge clk) begin
		if (reset_i) begin
			wr_ptr   <= '0;
			rd_ptr   <= '0;
			count    <= '0;
			credit_o <= 1'b0;
		end else begin
			if (link_i.valid) begin
				wr_ptr <= ptr_next(wr_ptr);
			end
			if (pop_i) begin
				rd_ptr <= ptr_next(rd_ptr);
			end
			// Push and pop in one cycle leave the level unchanged
			case ({link_i.valid, pop_i})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
			// Freed slot goes back upstream one cycle after the pop
			credit_o <= pop_i;
		end
	end

	assign head_o      = mem[rd_ptr];
	assign not_empty_o = (count != '0);

endmodule

`default_nettype wire

/* design/noc_pkg.sv */
`default_nettype none

package noc_pkg;

	localparam int NUM_PORTS = 5;

	// One mesh coordinate, row or column
	typedef logic [3:0] coord_t;

	typedef logic [7:0] payload_t;

	// Same field layout as the mesh router address
	typedef struct packed {
		payload_t payload;
		coord_t   col;
		coord_t   row;
	} flit_t;

	// Data direction of one link
	typedef struct packed {
		logic  valid;
		flit_t flit;
	} link_t;

	typedef enum logic [2:0] {
		PORT_NORTH = 3'd0,
		PORT_SOUTH = 3'd1,
		PORT_WEST  = 3'd2,
		PORT_EAST  = 3'd3,
		PORT_LOCAL = 3'd4
	} port_e;

	// One bit per port, indexed by port_e
	typedef logic [NUM_PORTS-1:0] port_vec_t;

endpackage

`default_nettype wire

/* design/noc_router.sv */
`timescale 1ns/1ps
`default_nettype none

module noc_router #(
	parameter noc_pkg::coord_t ROUTER_X     = 4'd1,
	parameter noc_pkg::coord_t ROUTER_Y     = 4'd1,
	parameter int              BUFFER_DEPTH = 4
) (
	input  wire logic          clk,
	input  wire logic          reset_i,
	input  noc_pkg::link_t     in_link_i [noc_pkg::NUM_PORTS],
	input  noc_pkg::port_vec_t credit_i,
	output noc_pkg::link_t     out_link_o [noc_pkg::NUM_PORTS],
	output noc_pkg::port_vec_t credit_o
);

	noc_pkg::flit_t     head [noc_pkg::NUM_PORTS];
	noc_pkg::port_vec_t not_empty;
	noc_pkg::port_vec_t request [noc_pkg::NUM_PORTS];
	noc_pkg::port_vec_t ready;
	noc_pkg::port_vec_t pop;
	noc_pkg::link_t     xbar_link [noc_pkg::NUM_PORTS];

	// Input side: buffer then route decode
	for (genvar i = 0; i < noc_pkg::NUM_PORTS; i++) begin : gen_input
		input_buffer #(
			.BUFFER_DEPTH(BUFFER_DEPTH)
		) u_input_buffer (
			.clk         (clk),
			.reset_i     (reset_i),
			.link_i      (in_link_i[i]),
			.pop_i       (pop[i]),
			.head_o      (head[i]),
			.not_empty_o (not_empty[i]),
			.credit_o    (credit_o[i])
		);

		yx_route_decode #(
			.ROUTER_X(ROUTER_X),
			.ROUTER_Y(ROUTER_Y)
		) u_yx_route_decode (
			.head_i      (head[i]),
			.not_empty_i (not_empty[i]),
			.request_o   (request[i])
		);
	end

	switch_allocator u_switch_allocator (
		.clk       (clk),
		.reset_i   (reset_i),
		.request_i (request),
		.head_i    (head),
		.ready_i   (ready),
		.pop_o     (pop),
		.link_o    (xbar_link)
	);

	// Output side: credit tracking and output register
	for (genvar o = 0; o < noc_pkg::NUM_PORTS; o++) begin : gen_output
		output_port #(
			.BUFFER_DEPTH(BUFFER_DEPTH)
		) u_output_port (
			.clk      (clk),
			.reset_i  (reset_i),
			.link_i   (xbar_link[o]),
			.credit_i (credit_i[o]),
			.link_o   (out_link_o[o]),
			.ready_o  (ready[o])
		);
	end

endmodule

`default_nettype wire

/* design/output_port.sv */
`timescale 1ns/1ps
`default_nettype none

module output_port #(
	parameter int BUFFER_DEPTH = 4
) (
	input  wire logic      clk,
	input  wire logic      reset_i,
	input  noc_pkg::link_t link_i,
	input  wire logic      credit_i,
	output noc_pkg::link_t link_o,
	output logic           ready_o
);

	localparam int CNT_W = $clog2(BUFFER_DEPTH + 1);

	typedef logic [CNT_W-1:0] cnt_t;

	// Free slots in the downstream input buffer
	cnt_t           credit_cnt;
	logic           valid_q;
	noc_pkg::flit_t flit_q;

	always_ff @(posedge clk) begin
		if (reset_i) begin
			credit_cnt <= cnt_t'(BUFFER_DEPTH);
		end else begin
			case ({link_i.valid, credit_i})
				2'b10:   credit_cnt <= credit_cnt - 1'b1;
				2'b01:   credit_cnt <= credit_cnt + 1'b1;
				default: credit_cnt <= credit_cnt;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (reset_i) begin
			valid_q <= 1'b0;
		end else begin
			valid_q <= link_i.valid;
		end
	end

	always_ff @(posedge clk) begin
		flit_q <= link_i.flit;
	end

	assign ready_o      = (credit_cnt != '0);
	assign link_o.valid = valid_q;
	assign link_o.flit  = flit_q;

endmodule

`default_nettype wire

/* design/switch_allocator.sv */
`timescale 1ns/1ps
`default_nettype none

module switch_allocator (
	input  wire logic          clk,
	input  wire logic          reset_i,
	input  noc_pkg::port_vec_t request_i [noc_pkg::NUM_PORTS],
	input  noc_pkg::flit_t     head_i [noc_pkg::NUM_PORTS],
	input  noc_pkg::port_vec_t ready_i,
	output noc_pkg::port_vec_t pop_o,
	output noc_pkg::link_t     link_o [noc_pkg::NUM_PORTS]
);

	localparam int N = noc_pkg::NUM_PORTS;

	// Requests seen per output, one bit per input
	noc_pkg::port_vec_t req_col [N];
	// Winning input per output, one-hot
	noc_pkg::port_vec_t grant [N];
	noc_pkg::port_e     rr_ptr [N];
	noc_pkg::port_e     ptr_next [N];

	// First requester at or after ptr, in port order
	function automatic noc_pkg::port_vec_t rr_pick(
		input noc_pkg::port_vec_t req,
		input noc_pkg::port_e     ptr
	);
		noc_pkg::port_vec_t gnt;
		int                 idx;
		gnt = '0;
		for (int k = N - 1; k >= 0; k--) begin
			idx = (int'(ptr) + k) % N;
			if (req[idx]) begin
				gnt      = '0;
				gnt[idx] = 1'b1;
			end
		end
		return gnt;
	endfunction

	always_comb begin
		pop_o = '0;
		for (int o = 0; o < N; o++) begin
			for (int i = 0; i < N; i++) begin
				req_col[o][i] = request_i[i][o];
			end
			grant[o] = ready_i[o] ? rr_pick(req_col[o], rr_ptr[o]) : '0;

			link_o[o].valid = |grant[o];
			link_o[o].flit  = '0;
			ptr_next[o]     = rr_ptr[o];
			for (int i = 0; i < N; i++) begin
				if (grant[o][i]) begin
					link_o[o].flit = head_i[i];
					ptr_next[o] = (i == N - 1) ? noc_pkg::PORT_NORTH
						: noc_pkg::port_e'(i + 1);
				end
			end
			// Each input requests one output, so it wins at most once
			pop_o = pop_o | grant[o];
		end
	end

	always_ff @(posedge clk) begin
		for (int o = 0; o < N; o++) begin
			if (reset_i) begin
				rr_ptr[o] <= noc_pkg::PORT_NORTH;
			end else begin
				rr_ptr[o] <= ptr_next[o];
			end
		end
	end

endmodule

`default_nettype wire

/* design/yx_route_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module yx_route_decode #(
	parameter noc_pkg::coord_t ROUTER_X = 4'd1,
	parameter noc_pkg::coord_t ROUTER_Y = 4'd1
) (
	input  noc_pkg::flit_t     head_i,
	input  wire logic          not_empty_i,
	output noc_pkg::port_vec_t request_o
);

	// Row is settled before column
	always_comb begin
		request_o = '0;
		if (not_empty_i) begin
			if (head_i.row < ROUTER_Y) begin
				request_o[noc_pkg::PORT_NORTH] = 1'b1;
			end else if (head_i.row > ROUTER_Y) begin
				request_o[noc_pkg::PORT_SOUTH] = 1'b1;
			end else if (head_i.col < ROUTER_X) begin
				request_o[noc_pkg::PORT_WEST] = 1'b1;
			end else if (head_i.col > ROUTER_X) begin
				request_o[noc_pkg::PORT_EAST] = 1'b1;
			end else begin
				request_o[noc_pkg::PORT_LOCAL] = 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

/* flist.f */
design/noc_pkg.sv
design/input_buffer.sv
design/yx_route_decode.sv
design/switch_allocator.sv
design/output_port.sv
design/noc_router.sv
verification/noc_router_chk.sv
verification/tb_noc_router.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the router testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_noc_router -f flist.f -o tb_noc_router
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/tb_noc_router > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "\*\*\* TEST FAILED \*\*\*" "$LOG"; then
	exit 1
fi
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi
exit 0

/* verification/noc_router_chk.sv */
`timescale 1ns/1ps
`default_nettype none

module noc_router_chk #(
	parameter int BUFFER_DEPTH = 4
) (
	input wire logic          clk,
	input wire logic          reset_i,
	input noc_pkg::link_t     out_link_o [noc_pkg::NUM_PORTS],
	input noc_pkg::port_vec_t credit_i,
	input noc_pkg::port_vec_t credit_o
);

	noc_pkg::port_vec_t out_valid;
	// Free downstream slots, seen from the link side only
	int                 free_slots [noc_pkg::NUM_PORTS];

	always_ff @(posedge clk) begin
		for (int o = 0; o < noc_pkg::NUM_PORTS; o++) begin
			if (reset_i) begin
				free_slots[o] <= BUFFER_DEPTH;
			end else begin
				free_slots[o] <= free_slots[o] - int'(out_link_o[o].valid)
					+ int'(credit_i[o]);
			end
		end
	end

	for (genvar o = 0; o < noc_pkg::NUM_PORTS; o++) begin : gen_port
		assign out_valid[o] = out_link_o[o].valid;

		// A flit may only leave while the downstream buffer has room
		a_credit_held : assert property (
			@(posedge clk) disable iff (reset_i)
			out_link_o[o].valid |-> (free_slots[o] > 0)
		) else $error("output %0d sent a flit without a downstream credit", o);
	end

	a_reset_quiet : assert property (
		@(posedge clk)
		(reset_i && $past(reset_i)) |-> (credit_o == '0 && out_valid == '0)
	) else $error("router outputs active during reset");

endmodule

bind noc_router noc_router_chk #(
	.BUFFER_DEPTH(BUFFER_DEPTH)
) u_chk (
	.clk        (clk),
	.reset_i    (reset_i),
	.out_link_o (out_link_o),
	.credit_i   (credit_i),
	.credit_o   (credit_o)
);

`default_nettype wire

/* verification/tb_noc_router.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_noc_router;

	localparam int N          = noc_pkg::NUM_PORTS;
	localparam int DEPTH      = 4;
	localparam int TABLE_LEN  = 31;
	localparam int CYCLE_LIMIT = TABLE_LEN * 20 + 100;

	typedef struct {
		int          in_port;
		logic [3:0]  col;
		logic [3:0]  row;
		logic [7:0]  payload;
		int          gap;
		int          exp_port;
		bit          lat;
	} entry_t;

	typedef struct {
		noc_pkg::flit_t flit;
		int             cyc;
		bit             lat;
	} exp_entry_t;

	logic               clk;
	logic               reset_i;
	noc_pkg::link_t     in_link_i [N];
	noc_pkg::port_vec_t credit_i;
	noc_pkg::link_t     out_link_o [N];
	noc_pkg::port_vec_t credit_o;

	entry_t         tbl [TABLE_LEN];
	// Indexed by output * N + input
	exp_entry_t     exp_q [N*N][$];
	noc_pkg::link_t pend [N];
	int             up_credit [N];
	int             recv_cnt [N];
	int             ret_cnt [N];
	bit             hold [N];
	int             east_log [$];
	int             cycles;

	noc_router #(
		.ROUTER_X     (4'd1),
		.ROUTER_Y     (4'd1),
		.BUFFER_DEPTH (DEPTH)
	) uut (
		.clk        (clk),
		.reset_i    (reset_i),
		.in_link_i  (in_link_i),
		.credit_i   (credit_i),
		.out_link_o (out_link_o),
		.credit_o   (credit_o)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	task automatic fail_now(input string why);
		$display("%s", why);
		$display("*** TEST FAILED ***");
		$fatal(1, "stopped at first error");
	endtask

	// Row first, then column, against router (1,1)
	function automatic int yx_expect(input logic [3:0] col, input logic [3:0] row);
		if (row < 4'd1) return 0;
		if (row > 4'd1) return 1;
		if (col < 4'd1) return 2;
		if (col > 4'd1) return 3;
		return 4;
	endfunction

	task automatic set_entry(input int idx, input int in_port, input int col, input int row,
			input int gap, input int exp_port, input bit lat);
		tbl[idx].in_port  = in_port;
		tbl[idx].col      = col[3:0];
		tbl[idx].row      = row[3:0];
		// Top bits name the source so the monitor can find its queue
		tbl[idx].payload  = {in_port[2:0], 5'($urandom)};
		tbl[idx].gap      = gap;
		tbl[idx].exp_port = exp_port;
		tbl[idx].lat      = lat;
	endtask

	task automatic build_table();
		set_entry(0, 4, 1, 0, 4, 0, 1);
		set_entry(1, 4, 1, 2, 4, 1, 1);
		set_entry(2, 4, 0, 1, 4, 2, 1);
		set_entry(3, 4, 2, 1, 4, 3, 1);
		set_entry(4, 4, 1, 1, 4, 4, 1);
		set_entry(5, 4, 0, 0, 4, 0, 1);
		set_entry(6, 4, 2, 2, 4, 1, 1);
		// Two bursts to east
		set_entry(7, 0, 2, 1, 6, 3, 0);
		set_entry(8, 2, 2, 1, 0, 3, 0);
		set_entry(9, 4, 2, 1, 0, 3, 0);
		set_entry(10, 0, 2, 1, 1, 3, 0);
		set_entry(11, 2, 2, 1, 0, 3, 0);
		set_entry(12, 4, 2, 1, 0, 3, 0);
		for (int k = 13; k < 19; k++) begin
			set_entry(k, 2, 1, 2, (k == 13) ? 4 : 1, 1, 0);
		end
		for (int k = 19; k < TABLE_LEN; k++) begin
			set_entry(k, $urandom % N, $urandom % 3, $urandom % 3, $urandom % 3, 0, 0);
			tbl[k].exp_port = yx_expect(tbl[k].col, tbl[k].row);
		end
	endtask

	// One clock edge carrying whatever is pending
	task automatic drive_cycle();
		@(posedge clk);
		for (int i = 0; i < N; i++) begin
			in_link_i[i] <= pend[i];
			pend[i].valid = 1'b0;
		end
	endtask

	task automatic apply_range(input int lo, input int hi);
		exp_entry_t e;
		int         p;
		for (int k = lo; k <= hi; k++) begin
			p = tbl[k].in_port;
			assert (tbl[k].exp_port == yx_expect(tbl[k].col, tbl[k].row))
			else fail_now($sformatf("table entry %0d has a wrong expected port", k));
			if (tbl[k].gap > 0) begin
				repeat (tbl[k].gap) drive_cycle();
			end
			while (up_credit[p] == 0 || pend[p].valid) begin
				drive_cycle();
			end
			pend[p].valid        = 1'b1;
			pend[p].flit.payload = tbl[k].payload;
			pend[p].flit.col     = tbl[k].col;
			pend[p].flit.row     = tbl[k].row;
			up_credit[p]--;
			e.flit = pend[p].flit;
			// The flit reaches the input in the cycle after the next edge count
			e.cyc  = cycles + 1;
			e.lat  = tbl[k].lat;
			exp_q[tbl[k].exp_port * N + p].push_back(e);
		end
		drive_cycle();
		drive_cycle();
	endtask

	task automatic wait_drain();
		int left;
		do begin
			@(negedge clk);
			left = 0;
			for (int q = 0; q < N*N; q++) left += exp_q[q].size();
		end while (left != 0);
	endtask

	// Downstream sink returns one credit per cycle unless held
	always @(posedge clk) begin
		for (int o = 0; o < N; o++) begin
			if (!hold[o] && recv_cnt[o] > ret_cnt[o]) begin
				credit_i[o] <= 1'b1;
				ret_cnt[o]  = ret_cnt[o] + 1;
			end else begin
				credit_i[o] <= 1'b0;
			end
		end
	end

	// Scoreboard, credit return and timeout, all sampled mid-cycle
	always @(negedge clk) begin : monitor
		exp_entry_t front;
		int         inp;
		for (int o = 0; o < N; o++) begin
			if (!reset_i && out_link_o[o].valid) begin
				inp = int'(out_link_o[o].flit.payload[7:5]);
				assert (inp < N && exp_q[o * N + inp].size() > 0)
				else fail_now($sformatf("unexpected flit %h on output %0d",
					out_link_o[o].flit, o));
				front = exp_q[o * N + inp].pop_front();
				assert (out_link_o[o].flit == front.flit)
				else fail_now($sformatf("ERROR %0t: out_link_o[%0d].flit expected %h got %h",
					$time, o, front.flit, out_link_o[o].flit));
				if (front.lat) begin
					assert (cycles - front.cyc == 2)
					else fail_now($sformatf("ERROR %0t: latency expected 2 got %0d",
						$time, cycles - front.cyc));
					assert (credit_o[inp])
					else fail_now($sformatf("ERROR %0t: credit_o[%0d] expected 1 got 0",
						$time, inp));
				end
				recv_cnt[o]++;
				if (o == 3) east_log.push_back(inp);
			end
		end
		for (int i = 0; i < N; i++) begin
			if (!reset_i && credit_o[i]) up_credit[i]++;
		end
		cycles++;
		if (cycles > CYCLE_LIMIT) begin
			fail_now("timeout: flits did not drain within the cycle limit");
		end
	end

	initial begin
		int unused;
		int base;
		int order [6];
		order = '{0, 2, 4, 0, 2, 4};
		unused = $urandom(32'hb6ed_ae41);
		cycles = 0;
		reset_i = 1'b1;
		credit_i = '0;
		for (int i = 0; i < N; i++) begin
			in_link_i[i] = '0;
			pend[i] = '0;
			up_credit[i] = DEPTH;
			recv_cnt[i] = 0;
			ret_cnt[i] = 0;
			hold[i] = 1'b0;
		end
		build_table();
		repeat (8) @(posedge clk);
		reset_i <= 1'b0;

		apply_range(0, 6);
		wait_drain();

		east_log.delete();
		apply_range(7, 12);
		wait_drain();
		for (int k = 0; k < 6; k++) begin
			assert (east_log[k] == order[k])
			else fail_now($sformatf("ERROR %0t: east grant %0d expected input %0d got %0d",
				$time, k, order[k], east_log[k]));
		end

		hold[1] = 1'b1;
		base = recv_cnt[1];
		apply_range(13, 18);
		repeat (20) @(negedge clk);
		assert (recv_cnt[1] - base == DEPTH)
		else fail_now($sformatf(
			"ERROR %0t: south flits under back-pressure expected %0d got %0d",
			$time, DEPTH, recv_cnt[1] - base));
		hold[1] = 1'b0;
		wait_drain();

		apply_range(19, TABLE_LEN - 1);
		wait_drain();

		$display("*** TEST PASSED ***");
		$finish;
	end

endmodule

`default_nettype wire
